//--- rtl/board_material.sv
`timescale 1ns/1ns

module board_material import chess_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic [BOARD_WIDTH-1:0]                       board,
   input  logic                                         start,
   input  logic signed [VALUED_KINDS*EVAL_WIDTH-1:0]    mg_values,
   input  logic signed [VALUED_KINDS*EVAL_WIDTH-1:0]    eg_values,
   output logic signed [EVAL_WIDTH+$clog2(SQUARES)-1:0] mg_total,
   output logic signed [EVAL_WIDTH+$clog2(SQUARES)-1:0] eg_total,
   output logic                                         material_valid
);

   localparam int RANK_WIDTH  = EVAL_WIDTH + $clog2(FILES);   // Eight squares
   localparam int TOTAL_WIDTH = EVAL_WIDTH + $clog2(SQUARES);

   logic signed [RANK_WIDTH-1:0]  rank_mg_c [RANKS];
   logic signed [RANK_WIDTH-1:0]  rank_eg_c [RANKS];
   logic signed [RANK_WIDTH-1:0]  rank_mg [RANKS];           // Stage one
   logic signed [RANK_WIDTH-1:0]  rank_eg [RANKS];
   logic signed [TOTAL_WIDTH-1:0] tot_mg_c;
   logic signed [TOTAL_WIDTH-1:0] tot_eg_c;
   logic                          start_d;                   // Stage one valid

   // Per square value, plus for white and minus for black
   always_comb
   begin : square_sum
      piece_t                       sq;
      logic                         valued;
      logic signed [EVAL_WIDTH-1:0] mg_v;
      logic signed [EVAL_WIDTH-1:0] eg_v;
      for (int r = 0; r < RANKS; r++)
      begin
         rank_mg_c[r] = '0;
         rank_eg_c[r] = '0;
      end
      for (int s = 0; s < SQUARES; s++)
      begin
         sq     = board[s*PIECE_WIDTH +: PIECE_WIDTH];
         valued = (sq.f.kind != KIND_EMPTY) && (sq.f.kind <= KIND_QUEEN); // King, 7 are 0
         mg_v   = '0;
         eg_v   = '0;
         if (valued)
         begin
            mg_v = mg_values[(sq.f.kind - KIND_PAWN)*EVAL_WIDTH +: EVAL_WIDTH];
            eg_v = eg_values[(sq.f.kind - KIND_PAWN)*EVAL_WIDTH +: EVAL_WIDTH];
         end
         if (sq.f.black)
         begin
            rank_mg_c[s / FILES] -= mg_v;
            rank_eg_c[s / FILES] -= eg_v;
         end
         else
         begin
            rank_mg_c[s / FILES] += mg_v;
            rank_eg_c[s / FILES] += eg_v;
         end
      end
   end

   // Stage two adds up the ranks
   always_comb
   begin
      tot_mg_c = '0;
      tot_eg_c = '0;
      for (int r = 0; r < RANKS; r++)
      begin
         tot_mg_c += rank_mg[r];
         tot_eg_c += rank_eg[r];
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         rank_mg <= rank_mg_c;                 // Capture on the start pulse
         rank_eg <= rank_eg_c;
      end
      mg_total <= tot_mg_c;
      eg_total <= tot_eg_c;
   end

   // Valid follows start two edges behind
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_d        <= 1'b0;
         material_valid <= 1'b0;
      end
      else
      begin
         start_d        <= start;
         material_valid <= start_d;
      end
   end

endmodule

//--- rtl/chess_pkg.sv
package chess_pkg;

   // Board geometry
   localparam int SQUARES     = 64;                    // Whole board
   localparam int RANKS       = 8;
   localparam int FILES       = 8;                     // Squares per rank
   localparam int PIECE_WIDTH = 4;                     // Bits per square code
   localparam int BOARD_WIDTH = SQUARES * PIECE_WIDTH; // Square 0 in low bits

   // One square code, read either as a word or as colour plus kind
   typedef union packed {
      logic [PIECE_WIDTH-1:0] code;                    // Zero is an empty square
      struct packed {
         logic                   black;                // Set for black
         logic [PIECE_WIDTH-2:0] kind;                 // KIND_* below
      } f;
   } piece_t;

   // Piece kinds, codes 7 and 15 read as empty
   localparam logic [PIECE_WIDTH-2:0] KIND_EMPTY  = 3'd0;
   localparam logic [PIECE_WIDTH-2:0] KIND_PAWN   = 3'd1;
   localparam logic [PIECE_WIDTH-2:0] KIND_KNIGHT = 3'd2;
   localparam logic [PIECE_WIDTH-2:0] KIND_BISHOP = 3'd3;
   localparam logic [PIECE_WIDTH-2:0] KIND_ROOK   = 3'd4;
   localparam logic [PIECE_WIDTH-2:0] KIND_QUEEN  = 3'd5;
   localparam logic [PIECE_WIDTH-2:0] KIND_KING   = 3'd6;

   localparam int VALUED_KINDS = 5;                    // Pawn to queen, king worth 0

   // Tapered blend
   localparam int PHASE_MAX   = 62;                    // Phase ceiling
   localparam int PHASE_WIDTH = 7;
   localparam int BLEND_SCALE = 16912;                 // 2**20 / 62 rounded down
   localparam int BLEND_SHIFT = 20;                    // Divide by 2**20

endpackage

//--- rtl/eval_control.sv
`timescale 1ns/1ns

module eval_control import chess_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  logic [BOARD_WIDTH-1:0] board_in,
   input  logic                   clear_eval,
   output logic [BOARD_WIDTH-1:0] board,
   output logic                   start,
   output logic                   eval_valid
);

   localparam int EVAL_LATENCY = 7;                 // Capture edge to eval_valid
   localparam int CNT_WIDTH    = $clog2(EVAL_LATENCY);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_COUNT = 2'd1;          // Pipeline in flight
   localparam logic [1:0] ST_HOLD  = 2'd2;          // Result held for consumer

   logic [1:0]           state;
   logic [CNT_WIDTH-1:0] cnt;
   logic                 board_valid_r;
   logic                 board_edge;

   assign board_edge = board_valid && !board_valid_r;  // Rising edge only

   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && board_edge)
         board <= board_in;                         // Held until the next capture
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         cnt           <= '0;
         board_valid_r <= 1'b0;
         start         <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         start         <= 1'b0;
         case (state)
            ST_IDLE:
               if (board_edge)
               begin
                  start <= 1'b1;
                  cnt   <= CNT_WIDTH'(EVAL_LATENCY - 1);
                  state <= ST_COUNT;
               end
            ST_COUNT:
               if (cnt == '0)
               begin
                  eval_valid <= 1'b1;
                  state      <= ST_HOLD;
               end
               else
                  cnt <= cnt - 1'b1;
            ST_HOLD:
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= ST_IDLE;
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   a_start_pulse: assert property (@(posedge clk) disable iff (reset)
      start |=> !start);

   // Result only after a full pass through the datapath
   a_valid_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(eval_valid) |-> $past(start, EVAL_LATENCY));

endmodule

//--- rtl/eval_reg_map_pkg.sv
package eval_reg_map_pkg;

   // APB bus widths
   localparam int APB_ADDR_WIDTH = 8;
   localparam int APB_DATA_WIDTH = 32;

   localparam int REG_STRIDE = 4;                      // Byte step between value words

   // Middlegame values at 0x00 to 0x10, pawn first
   localparam logic [APB_ADDR_WIDTH-1:0] REG_MG_BASE = 8'h00;

   // Endgame values at 0x20 to 0x30, pawn first
   localparam logic [APB_ADDR_WIDTH-1:0] REG_EG_BASE = 8'h20;

endpackage

//--- rtl/eval_regs.sv
`timescale 1ns/1ns

module eval_regs import chess_pkg::*, eval_reg_map_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      psel,
   input  logic                                      penable,
   input  logic                                      pwrite,
   input  logic [APB_ADDR_WIDTH-1:0]                 paddr,
   input  logic [APB_DATA_WIDTH-1:0]                 pwdata,
   output logic [APB_DATA_WIDTH-1:0]                 prdata,
   output logic                                      pslverr,
   output logic signed [VALUED_KINDS*EVAL_WIDTH-1:0] mg_values,
   output logic signed [VALUED_KINDS*EVAL_WIDTH-1:0] eg_values
);

   localparam int IDX_WIDTH   = $clog2(VALUED_KINDS);
   localparam int STRIDE_LOG2 = $clog2(REG_STRIDE);
   localparam int TABLE_SPAN  = VALUED_KINDS * REG_STRIDE;  // Bytes per table

   logic signed [EVAL_WIDTH-1:0] mg_tab [VALUED_KINDS];     // Middlegame values
   logic signed [EVAL_WIDTH-1:0] eg_tab [VALUED_KINDS];     // Endgame values
   logic [APB_ADDR_WIDTH-1:0]    mg_off;
   logic [APB_ADDR_WIDTH-1:0]    eg_off;
   logic                         hit_mg;
   logic                         hit_eg;
   logic [IDX_WIDTH-1:0]         idx_mg;
   logic [IDX_WIDTH-1:0]         idx_eg;
   logic signed [EVAL_WIDTH-1:0] rd_val;

   // Address decode, offsets wrap high below a base
   assign mg_off = paddr - REG_MG_BASE;
   assign eg_off = paddr - REG_EG_BASE;
   assign hit_mg = (mg_off < TABLE_SPAN) && (mg_off[STRIDE_LOG2-1:0] == '0);
   assign hit_eg = (eg_off < TABLE_SPAN) && (eg_off[STRIDE_LOG2-1:0] == '0);
   assign idx_mg = mg_off[STRIDE_LOG2 +: IDX_WIDTH];        // Word index, pawn is 0
   assign idx_eg = eg_off[STRIDE_LOG2 +: IDX_WIDTH];

   assign rd_val = hit_mg ? mg_tab[idx_mg] :
                   hit_eg ? eg_tab[idx_eg] : '0;            // Unmapped reads 0

   // Table writes at the access edge
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int k = 0; k < VALUED_KINDS; k++)
         begin
            mg_tab[k] <= '0;
            eg_tab[k] <= '0;
         end
      end
      else if (psel && penable && pwrite)
      begin
         if (hit_mg)
            mg_tab[idx_mg] <= pwdata[EVAL_WIDTH-1:0];       // Low bits only
         else if (hit_eg)
            eg_tab[idx_eg] <= pwdata[EVAL_WIDTH-1:0];
      end
   end

   // Response built at the setup edge, shown during the access cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end
      else
      begin
         pslverr <= psel && !penable && !(hit_mg || hit_eg); // Cleared at access edge
         if (psel && !penable)
            prdata <= APB_DATA_WIDTH'(rd_val);               // Sign extended
      end
   end

   // Tables to the datapath as flat vectors
   always_comb
   begin
      for (int k = 0; k < VALUED_KINDS; k++)
      begin
         mg_values[k*EVAL_WIDTH +: EVAL_WIDTH] = mg_tab[k];
         eg_values[k*EVAL_WIDTH +: EVAL_WIDTH] = eg_tab[k];
      end
   end

   // Error response only ever shows in an access cycle
   a_err_in_access: assert property (@(posedge clk) disable iff (reset)
      pslverr |-> (psel && penable));

endmodule

//--- rtl/eval_top.sv
`timescale 1ns/1ns

module eval_top import chess_pkg::*, eval_reg_map_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [APB_ADDR_WIDTH-1:0]    paddr,
   input  logic [APB_DATA_WIDTH-1:0]    pwdata,
   output logic [APB_DATA_WIDTH-1:0]    prdata,
   output logic                         pslverr,
   input  logic                         board_valid,
   input  logic [BOARD_WIDTH-1:0]       board_in,
   input  logic                         clear_eval,
   output logic signed [EVAL_WIDTH-1:0] eval,
   output logic                         eval_valid
);

   localparam int TOTAL_WIDTH = EVAL_WIDTH + $clog2(SQUARES);  // Material sums

   logic [BOARD_WIDTH-1:0]                    board;        // Latched board
   logic                                      start;
   logic signed [VALUED_KINDS*EVAL_WIDTH-1:0] mg_values;
   logic signed [VALUED_KINDS*EVAL_WIDTH-1:0] eg_values;
   logic signed [TOTAL_WIDTH-1:0]             mg_total;
   logic signed [TOTAL_WIDTH-1:0]             eg_total;
   logic                                      material_valid;
   logic [PHASE_WIDTH-1:0]                    phase;

   eval_regs #(.EVAL_WIDTH(EVAL_WIDTH)) u_eval_regs (
      .clk       (clk),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pslverr   (pslverr),
      .mg_values (mg_values),
      .eg_values (eg_values)
   );

   eval_control u_eval_control (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .board       (board),
      .start       (start),
      .eval_valid  (eval_valid)
   );

   // Material and phase land on the same edge
   board_material #(.EVAL_WIDTH(EVAL_WIDTH)) u_board_material (
      .clk            (clk),
      .reset          (reset),
      .board          (board),
      .start          (start),
      .mg_values      (mg_values),
      .eg_values      (eg_values),
      .mg_total       (mg_total),
      .eg_total       (eg_total),
      .material_valid (material_valid)
   );

   phase_count u_phase_count (
      .clk   (clk),
      .reset (reset),
      .board (board),
      .start (start),
      .phase (phase)
   );

   phase_blend #(.EVAL_WIDTH(EVAL_WIDTH)) u_phase_blend (
      .clk            (clk),
      .reset          (reset),
      .mg_total       (mg_total),
      .eg_total       (eg_total),
      .phase          (phase),
      .material_valid (material_valid),
      .eval           (eval)
   );

endmodule

//--- rtl/phase_blend.sv
`timescale 1ns/1ns

module phase_blend import chess_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic signed [EVAL_WIDTH+$clog2(SQUARES)-1:0] mg_total,
   input  logic signed [EVAL_WIDTH+$clog2(SQUARES)-1:0] eg_total,
   input  logic [PHASE_WIDTH-1:0]                       phase,
   input  logic                                         material_valid,
   output logic signed [EVAL_WIDTH-1:0]                 eval
);

   localparam int TOTAL_WIDTH  = EVAL_WIDTH + $clog2(SQUARES);
   localparam int PROD_WIDTH   = TOTAL_WIDTH + PHASE_WIDTH + 1;
   localparam int SUM_WIDTH    = PROD_WIDTH + 1;
   localparam int SCALED_WIDTH = SUM_WIDTH + $clog2(BLEND_SCALE) + 1;
   localparam logic signed [SCALED_WIDTH-1:0] ROUND_BIAS = (1 << BLEND_SHIFT) - 1;

   logic [PHASE_WIDTH-1:0]         phase_eg;          // Endgame weight
   logic signed [PROD_WIDTH-1:0]   prod_mg;           // Stage 1
   logic signed [PROD_WIDTH-1:0]   prod_eg;
   logic signed [SUM_WIDTH-1:0]    sum_r;             // Stage 2
   logic signed [SCALED_WIDTH-1:0] scaled_r;          // Stage 3
   logic signed [SCALED_WIDTH-1:0] biased;
   logic                           v1;
   logic                           v2;
   logic                           v3;

   assign phase_eg = PHASE_WIDTH'(PHASE_MAX) - phase;

   // Negative values biased so the shift truncates toward zero
   assign biased = scaled_r[SCALED_WIDTH-1] ? scaled_r + ROUND_BIAS : scaled_r;

   always_ff @(posedge clk)
   begin
      if (material_valid)
      begin
         prod_mg <= mg_total * $signed({1'b0, phase});
         prod_eg <= eg_total * $signed({1'b0, phase_eg});
      end
      if (v1)
         sum_r <= prod_mg + prod_eg;
      if (v2)
         scaled_r <= sum_r * BLEND_SCALE;              // Stands in for divide by 62
      if (v3)
         eval <= EVAL_WIDTH'(biased >>> BLEND_SHIFT);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         v1 <= 1'b0;
         v2 <= 1'b0;
         v3 <= 1'b0;
      end
      else
      begin
         v1 <= material_valid;
         v2 <= v1;
         v3 <= v2;
      end
   end

   // Clamp in phase_count keeps the endgame weight non-negative
   a_phase_range: assert property (@(posedge clk) disable iff (reset)
      phase <= PHASE_MAX);

endmodule

//--- rtl/phase_count.sv
`timescale 1ns/1ns

module phase_count import chess_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [BOARD_WIDTH-1:0] board,
   input  logic                   start,
   output logic [PHASE_WIDTH-1:0] phase
);

   localparam int RCNT_WIDTH = $clog2(FILES + 1);   // 0 to 8 per rank
   localparam int SUM_WIDTH  = $clog2(SQUARES + 1);

   logic [RCNT_WIDTH-1:0] rank_cnt_c [RANKS];
   logic [RCNT_WIDTH-1:0] rank_cnt [RANKS];         // Stage one
   logic [SUM_WIDTH-1:0]  pieces;

   // Non-pawn pieces per rank with kings included
   always_comb
   begin : rank_count
      piece_t sq;
      for (int r = 0; r < RANKS; r++)
         rank_cnt_c[r] = '0;
      for (int s = 0; s < SQUARES; s++)
      begin
         sq.code = board[s*PIECE_WIDTH +: PIECE_WIDTH];
         if ((sq.f.kind > KIND_PAWN) && (sq.f.kind <= KIND_KING))
            rank_cnt_c[s / FILES] += 1'b1;
      end
   end

   always_comb
   begin
      pieces = '0;
      for (int r = 0; r < RANKS; r++)
         pieces += rank_cnt[r];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rank_cnt <= '{default: '0};
         phase    <= '0;
      end
      else
      begin
         if (start)
            rank_cnt <= rank_cnt_c;                 // Same edge as material stage one
         if (pieces > PHASE_MAX)
            phase <= PHASE_WIDTH'(PHASE_MAX);       // Clamp
         else
            phase <= PHASE_WIDTH'(pieces);
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the evaluator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module eval_top_tb -Mdir obj_dir -o eval_top_tb_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/eval_top_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
exit 0

//--- src.f
rtl/chess_pkg.sv
rtl/eval_reg_map_pkg.sv
rtl/eval_regs.sv
rtl/board_material.sv
rtl/phase_count.sv
rtl/phase_blend.sv
rtl/eval_control.sv
rtl/eval_top.sv
tb/eval_top_tb.sv

//--- tb/eval_top_tb.sv
`timescale 1ns/1ns

module eval_top_tb import chess_pkg::*, eval_reg_map_pkg::*;
();

   localparam int EVAL_WIDTH     = 16;
   localparam int CLK_PERIOD     = 10;
   localparam int LATENCY        = 7;                    // T0 to eval_valid
   localparam int TIMEOUT_CYCLES = 4000;                 // Tests take a few hundred cycles
   localparam int UPPER_WIDTH    = APB_DATA_WIDTH - EVAL_WIDTH;

   logic                         clk;
   logic                         reset;
   logic                         psel;
   logic                         penable;
   logic                         pwrite;
   logic [APB_ADDR_WIDTH-1:0]    paddr;
   logic [APB_DATA_WIDTH-1:0]    pwdata;
   logic [APB_DATA_WIDTH-1:0]    prdata;
   logic                         pslverr;
   logic                         board_valid;
   logic [BOARD_WIDTH-1:0]       board_in;
   logic                         clear_eval;
   logic signed [EVAL_WIDTH-1:0] eval;
   logic                         eval_valid;

   logic [31:0] lfsr;                                    // Random board source
   int          cycles;
   int          mg_vals [VALUED_KINDS];                  // Values now in the DUT tables
   int          eg_vals [VALUED_KINDS];

   eval_top #(.EVAL_WIDTH(EVAL_WIDTH)) u_eval_top (
      .clk         (clk),
      .reset       (reset),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pslverr     (pslverr),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Run limit
   initial
   begin
      cycles = 0;
      forever
      begin
         @(posedge clk);
         cycles++;
         if (cycles >= TIMEOUT_CYCLES)
         begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "Run stopped by cycle limit");
         end
      end
   end

   task automatic fail_value(input string name, input longint expected, input longint actual);
      $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [3:0] rand_nibble();
      logic [3:0] v;
      v = '0;
      for (int i = 0; i < 4; i++)
      begin
         lfsr = lfsr_step(lfsr);                         // One step per bit
         v    = {v[2:0], lfsr[0]};
      end
      return v;
   endfunction

   // 0 all non-pawn pieces, 1 any code, 2 one square per rank
   function automatic logic [BOARD_WIDTH-1:0] random_board(input int density);
      logic [BOARD_WIDTH-1:0] b;
      logic [3:0]             r;
      b = '0;
      for (int s = 0; s < SQUARES; s++)
      begin
         if (density == 2 && (s % 8) != 3)
            continue;
         r = rand_nibble();
         if (density == 0)
            b[s*4 +: 4] = {r[3], 3'(2 + r[2:0] % 5)};     // Knight to king
         else
            b[s*4 +: 4] = r;
      end
      return b;
   endfunction

   function automatic logic [BOARD_WIDTH-1:0] start_position();
      logic [3:0]             back [8];
      logic [BOARD_WIDTH-1:0] b;
      back = '{4'd4, 4'd2, 4'd3, 4'd5, 4'd6, 4'd3, 4'd2, 4'd4}; // R N B Q K B N R
      b    = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f*4 +: 4]        = back[f];                   // White back rank
         b[(8 + f)*4 +: 4]  = 4'd1;
         b[(48 + f)*4 +: 4] = 4'd9;                      // Black pawns
         b[(56 + f)*4 +: 4] = back[f] | 4'd8;
      end
      return b;
   endfunction

   // Signed worth of one square, white positive
   function automatic int piece_value(input logic [3:0] code, input bit endgame);
      int kind;
      int v;
      kind = code[2:0];
      v    = 0;
      if (kind >= 1 && kind <= 5)
         v = endgame ? eg_vals[kind - 1] : mg_vals[kind - 1];
      return code[3] ? -v : v;
   endfunction

   function automatic logic signed [EVAL_WIDTH-1:0] expected_eval(input logic [BOARD_WIDTH-1:0] b);
      longint     mg;
      longint     eg;
      longint     blended;
      int         phase;
      int         kind;
      logic [3:0] code;
      mg    = 0;
      eg    = 0;
      phase = 0;
      for (int s = 0; s < SQUARES; s++)
      begin
         code = b[s*4 +: 4];
         kind = code[2:0];
         mg  += piece_value(code, 1'b0);
         eg  += piece_value(code, 1'b1);
         if (kind >= 2 && kind <= 6)
            phase++;                                     // Kings count too
      end
      if (phase > 62)
         phase = 62;
      blended = (mg * phase + eg * (62 - phase)) * 16912;
      blended = blended / (longint'(1) << 20);           // Truncates toward zero
      return EVAL_WIDTH'(blended);
   endfunction

   // Setup, access, then idle
   task automatic apb_transfer(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                               input logic [APB_DATA_WIDTH-1:0] wdata,
                               output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);                                    // Mid access cycle
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic write_value(input string name, input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [APB_DATA_WIDTH-1:0] data, input logic exp_err);
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      apb_transfer(1'b1, addr, data, rd, err);
      assert (err == exp_err) else fail_value({name, " pslverr"}, exp_err, err);
   endtask

   task automatic check_read(input string name, input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [APB_DATA_WIDTH-1:0] exp, input logic exp_err);
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      apb_transfer(1'b0, addr, '0, rd, err);
      assert (rd == exp) else fail_value(name, $signed(exp), $signed(rd));
      assert (err == exp_err) else fail_value({name, " pslverr"}, exp_err, err);
   endtask

   // Upper bits of each word are junk the DUT drops
   task automatic load_values(input logic [UPPER_WIDTH-1:0] upper);
      for (int k = 0; k < VALUED_KINDS; k++)
      begin
         write_value("load_mg", 8'(REG_MG_BASE + 4*k), {upper, EVAL_WIDTH'(mg_vals[k])}, 1'b0);
         write_value("load_eg", 8'(REG_EG_BASE + 4*k), {upper, EVAL_WIDTH'(eg_vals[k])}, 1'b0);
      end
   endtask

   task automatic check_tables(input string name);
      logic [EVAL_WIDTH-1:0] lo;
      for (int k = 0; k < VALUED_KINDS; k++)
      begin
         lo = EVAL_WIDTH'(mg_vals[k]);
         check_read(name, 8'(REG_MG_BASE + 4*k), {{UPPER_WIDTH{lo[EVAL_WIDTH-1]}}, lo}, 1'b0);
         lo = EVAL_WIDTH'(eg_vals[k]);
         check_read(name, 8'(REG_EG_BASE + 4*k), {{UPPER_WIDTH{lo[EVAL_WIDTH-1]}}, lo}, 1'b0);
      end
   endtask

   // Present a board, count edges from T0 and check the result
   task automatic evaluate(input string name, input logic [BOARD_WIDTH-1:0] b);
      int                           edges;
      logic signed [EVAL_WIDTH-1:0] exp;
      exp = expected_eval(b);
      @(posedge clk);
      board_in    <= b;
      board_valid <= 1'b1;
      @(posedge clk);                                    // T0
      board_valid <= 1'b0;
      board_in    <= ~b;                                 // Only the latched copy counts
      edges = 0;
      do
      begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      while (!eval_valid && edges < 2 * LATENCY);
      assert (edges == LATENCY) else fail_value({name, " latency"}, LATENCY, edges);
      assert (eval == exp) else fail_value(name, exp, eval);
   endtask

   task automatic clear_result(input string name);
      @(posedge clk);
      clear_eval <= 1'b1;
      @(posedge clk);
      clear_eval <= 1'b0;
      @(negedge clk);
      assert (!eval_valid) else fail_value({name, " clear"}, 0, eval_valid);
   endtask

   task automatic reset_latency();
      @(negedge clk);
      assert (!eval_valid) else fail_value("reset eval_valid", 0, eval_valid);
      assert (!pslverr) else fail_value("reset pslverr", 0, pslverr);
      evaluate("latency", random_board(1));              // Zero tables give 0
      clear_result("latency");
   endtask

   task automatic register_access();
      check_tables("reg_reset");                         // All ten words start at 0
      mg_vals = '{-100, -320, -330, -500, -900};
      eg_vals = '{120, 290, 310, 540, 1000};
      load_values(16'hBEEF);
      check_tables("reg_readback");
      check_read("unmapped_read_14", 8'h14, '0, 1'b1);
      check_read("unmapped_read_34", 8'h34, '0, 1'b1);
      check_read("unmapped_read_fc", 8'hFC, '0, 1'b1);
      write_value("unmapped_write_14", 8'h14, 32'h0000_7777, 1'b1);
      write_value("unmapped_write_40", 8'h40, 32'h0000_5555, 1'b1);
      check_tables("reg_after_unmapped");                // Tables untouched
   endtask

   task automatic symmetric_start();
      evaluate("start_signed_values", start_position());
      assert (eval == 0) else fail_value("start_signed_values", 0, eval);
      clear_result("start_signed_values");
      mg_vals = '{82, 337, 365, 477, 1025};
      eg_vals = '{94, 281, 297, 512, 936};
      load_values('0);
      evaluate("start_standard_values", start_position());
      assert (eval == 0) else fail_value("start_standard_values", 0, eval);
      clear_result("start_standard_values");
   endtask

   task automatic random_positions();
      for (int i = 0; i < 20; i++)
      begin
         evaluate($sformatf("random_%0d", i), random_board(i % 3));
         clear_result($sformatf("random_%0d", i));
      end
   endtask

   // New boards during the hold must not disturb the result
   task automatic hold_and_clear();
      logic signed [EVAL_WIDTH-1:0] held;
      logic [BOARD_WIDTH-1:0]       first_board;
      logic [BOARD_WIDTH-1:0]       other;
      first_board = random_board(1);
      evaluate("hold_first", first_board);
      held  = expected_eval(first_board);
      other = random_board(0);
      for (int i = 0; i < 8; i++)
      begin
         @(posedge clk);
         board_in    <= other;
         board_valid <= (i % 2 == 0);                    // Ends low
         @(negedge clk);
         assert (eval_valid) else fail_value("hold eval_valid", 1, eval_valid);
         assert (eval == held) else fail_value("hold eval", held, eval);
      end
      clear_result("hold_first");
      evaluate("hold_next", other);
      clear_result("hold_next");
   endtask

   initial
   begin
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      board_valid = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      lfsr        = 32'he122;
      mg_vals     = '{0, 0, 0, 0, 0};                    // Reset state of the tables
      eg_vals     = '{0, 0, 0, 0, 0};
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      reset_latency();
      register_access();
      symmetric_start();
      random_positions();
      hold_and_clear();
      $display("TESTS PASSED");
      $finish;
   end

endmodule
